//--- sources.f
rtl/csr_reg_pkg.sv
rtl/csr_isa_pkg.sv
rtl/csr_decode.sv
rtl/csr_file.sv
rtl/csr_result.sv
rtl/csr_unit.sv
tests/csr_unit_checker.sv
tests/csr_unit_tb.sv

//--- Bender.yml
package:
  name: csr_unit

sources:
  # the ISA package refers to the register package
  - rtl/csr_reg_pkg.sv
  - rtl/csr_isa_pkg.sv
  - rtl/csr_decode.sv
  - rtl/csr_file.sv
  - rtl/csr_result.sv
  - rtl/csr_unit.sv
  - target: test
    files:
      - tests/csr_unit_checker.sv
      - tests/csr_unit_tb.sv

//--- tests/csr_unit_tb.sv
////////////////////////////////////////
// csr_unit testbench, XLEN 32 only
// model runs in the strobe cycle
////////////////////////////////////////

`timescale 1ns/1ns

module csr_unit_tb;

  localparam int unsigned XLEN    = 32;
  localparam logic [31:0] MTVEC   = 32'h0000_0100;
  localparam logic [31:0] HART_ID = 32'h0000_0003;
  localparam logic [31:0] MISA    = 32'h4000_0100;  // RV32I, MXL 1 and bit I
  localparam int          TMO     = 20;             // cycles per wait
  // six implemented, one unimplemented, one user-level address
  localparam logic [11:0] ADRS [8] = '{csr_reg_pkg::ADR_MISA, csr_reg_pkg::ADR_MSCRATCH,
    csr_reg_pkg::ADR_MTVEC, csr_reg_pkg::ADR_MEPC, csr_reg_pkg::ADR_MCAUSE,
    csr_reg_pkg::ADR_MHARTID, 12'h7C0, 12'h040};

  logic                 clk;
  logic                 rst;
  logic                 inst_vld_i;
  logic [31:0]          inst_i;
  logic [XLEN-1:0]      rs1_i;
  logic                 trap_i;
  logic [XLEN-1:0]      cause_i;
  logic [XLEN-1:0]      epc_i;
  csr_reg_pkg::csr_wb_t wb_o;
  logic [XLEN-1:0]      tvec_o;
  logic [XLEN-1:0]      epc_o;

  logic [31:0]          m_scratch;  // model registers
  logic [31:0]          m_tvec;
  logic [31:0]          m_epc;
  logic [31:0]          m_cause;
  csr_reg_pkg::csr_wb_t exp_q[$];   // results in flight
  string                test_name;
  int                   err_cnt;
  int                   tmo_cnt;
  integer               seed;

  csr_unit #(.XLEN(XLEN), .MTVEC(MTVEC), .HART_ID(HART_ID)) DUT (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  ////////////////////////////////////////
  // reference model and compare tasks
  ////////////////////////////////////////

  // expected writeback, also moves the model registers
  function automatic csr_reg_pkg::csr_wb_t model_csr(input logic [31:0] inst,
                                                     input logic [31:0] data);
    csr_reg_pkg::csr_wb_t r;
    logic [31:0] old;
    logic [31:0] opnd;
    logic [31:0] nxt;
    logic        known;
    logic        wr;
    r     = '0;
    old   = '0;
    known = 1'b1;
    case (inst[31:20])
      csr_reg_pkg::ADR_MISA:     old = MISA;
      csr_reg_pkg::ADR_MSCRATCH: old = m_scratch;
      csr_reg_pkg::ADR_MTVEC:    old = m_tvec;
      csr_reg_pkg::ADR_MEPC:     old = m_epc;
      csr_reg_pkg::ADR_MCAUSE:   old = m_cause;
      csr_reg_pkg::ADR_MHARTID:  old = HART_ID;
      default:                   known = 1'b0;
    endcase
    if (inst[6:0] != 7'b1110011 || inst[13:12] == 2'b00) return r;  // no csr op
    opnd  = inst[14] ? 32'(inst[19:15]) : data;  // uimm or rs1 data
    wr    = inst[13:12] == 2'b01 || inst[19:15] != 5'd0;
    r.vld = 1'b1;
    r.rd  = inst[11:7];
    // unknown, not M level, or a write to a read-only register
    r.ill = !known || inst[29:28] != 2'b11 || (wr && inst[31:30] == 2'b11);
    if (!r.ill && !(inst[13:12] == 2'b01 && inst[11:7] == 5'd0)) r.rdt = old;
    case (inst[13:12])
      2'b01:   nxt = opnd;
      2'b10:   nxt = old | opnd;
      default: nxt = old & ~opnd;
    endcase
    if (!r.ill && wr) begin
      case (inst[31:20])
        csr_reg_pkg::ADR_MSCRATCH: m_scratch = nxt;
        csr_reg_pkg::ADR_MTVEC:    m_tvec    = nxt;
        csr_reg_pkg::ADR_MEPC:     m_epc     = nxt;
        csr_reg_pkg::ADR_MCAUSE:   m_cause   = nxt;
        default: ;  // misa keeps its value
      endcase
    end
    return r;
  endfunction

  task automatic check_wb(input csr_reg_pkg::csr_wb_t exp, input csr_reg_pkg::csr_wb_t act);
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: expected vld/ill/rd/rdt %b/%b/%0d/%h, actual %b/%b/%0d/%h",
               test_name, exp.vld, exp.ill, exp.rd, exp.rdt, act.vld, act.ill, act.rd, act.rdt);
    end
  endtask

  task automatic check_vec(input string sig, input logic [XLEN-1:0] exp,
                           input logic [XLEN-1:0] act);
    if (act !== exp) begin
      err_cnt++;
      $display("error %s: %s expected %h, actual %h", test_name, sig, exp, act);
    end
  endtask

  task automatic report_verdict();
    $display("errors %0d, timeouts %0d, assertion failures %0d",
             err_cnt, tmo_cnt, DUT.u_checker.fail_cnt);
    if (err_cnt + tmo_cnt + DUT.u_checker.fail_cnt == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  endtask

  // one strobe, then wait for the compare process to take the result
  task automatic drive_cycle(input logic vld, input logic [31:0] inst, input logic [31:0] data,
                             input logic trap, input logic [31:0] cause, input logic [31:0] epc);
    csr_reg_pkg::csr_wb_t e;
    int n;
    @(posedge clk);
    inst_vld_i <= vld;
    inst_i     <= inst;
    rs1_i      <= data;
    trap_i     <= trap;
    cause_i    <= cause;
    epc_i      <= epc;
    if (trap) begin
      m_epc   = epc;  // trap wins, instruction dropped
      m_cause = cause;
    end else if (vld) begin
      e = model_csr(inst, data);
      if (e.vld) exp_q.push_back(e);
    end
    @(posedge clk);
    inst_vld_i <= 1'b0;
    trap_i     <= 1'b0;
    n = 0;
    while (exp_q.size() != 0 && n < TMO) begin
      @(posedge clk);
      n++;
    end
    if (exp_q.size() != 0) begin
      tmo_cnt++;
      $display("timeout: no result valid in %s", test_name);
      report_verdict();
    end
    @(negedge clk);
    check_vec("tvec_o", m_tvec, tvec_o);
    check_vec("epc_o", m_epc, epc_o);
  endtask

  task automatic run_csr(input logic [2:0] f3, input logic [11:0] adr, input logic [4:0] idx,
                         input logic [4:0] rd, input logic [31:0] data);
    drive_cycle(1'b1, {adr, idx, f3, rd, 7'b1110011}, data, 1'b0, '0, '0);
  endtask

  // compare process, wb_o sampled on the falling edge
  always @(negedge clk) begin
    if (!rst && wb_o.vld) begin
      if (exp_q.size() == 0) begin
        err_cnt++;
        $display("result valid without a pending instruction in %s", test_name);
      end else begin
        check_wb(exp_q.pop_front(), wb_o);
      end
    end
  end

  ////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] r;
    seed       = 32'h3cbf9d6d;
    err_cnt    = 0;
    tmo_cnt    = 0;
    rst        = 1'b1;
    inst_vld_i = 1'b0;
    inst_i     = '0;
    rs1_i      = '0;
    trap_i     = 1'b0;
    cause_i    = '0;
    epc_i      = '0;
    m_scratch  = '0;
    m_tvec     = MTVEC;
    m_epc      = '0;
    m_cause    = '0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;

    test_name = "reset";
    for (int k = 0; k < 6; k++) run_csr(3'b010, ADRS[k], 5'd0, 5'd1, '0);  // csrrs x1, x0

    test_name = "reg_ops";  // mscratch then mtvec
    for (int k = 1; k < 3; k++) begin
      run_csr(3'b001, ADRS[k], 5'd1, 5'd5, $random(seed));
      run_csr(3'b010, ADRS[k], 5'd2, 5'd6, $random(seed));
      run_csr(3'b011, ADRS[k], 5'd3, 5'd7, $random(seed));
      run_csr(3'b010, ADRS[k], 5'd0, 5'd8, '0);
    end

    test_name = "imm_ops";
    run_csr(3'b110, ADRS[1], 5'd0, 5'd1, '1);             // csrrsi, uimm 0
    run_csr(3'b111, ADRS[1], 5'd0, 5'd2, '1);             // csrrci, uimm 0
    run_csr(3'b101, ADRS[1], 5'd21, 5'd0, '0);            // csrrwi to x0 writes
    run_csr(3'b110, ADRS[1], 5'd10, 5'd3, '0);
    run_csr(3'b111, ADRS[1], 5'd3, 5'd4, '0);
    run_csr(3'b001, ADRS[3], 5'd9, 5'd0, 32'h8000_0040);  // csrrw x0 on mepc
    run_csr(3'b010, ADRS[3], 5'd0, 5'd5, '0);

    test_name = "illegal";
    run_csr(3'b001, ADRS[5], 5'd1, 5'd1, 32'h1234_5678);  // write mhartid
    run_csr(3'b110, ADRS[5], 5'd4, 5'd1, '0);
    run_csr(3'b010, ADRS[6], 5'd0, 5'd2, '0);             // unimplemented
    run_csr(3'b001, ADRS[7], 5'd1, 5'd3, 32'h55);         // user level field
    run_csr(3'b010, ADRS[5], 5'd0, 5'd4, '1);             // legal, reads HART_ID
    for (int k = 0; k < 6; k++) run_csr(3'b010, ADRS[k], 5'd0, 5'd1, '0);

    test_name = "trap";
    drive_cycle(1'b0, '0, '0, 1'b1, 32'h0000_000b, 32'h0000_2468);
    run_csr(3'b010, ADRS[3], 5'd0, 5'd1, '0);
    run_csr(3'b010, ADRS[4], 5'd0, 5'd1, '0);
    drive_cycle(1'b1, {ADRS[1], 5'd1, 3'b001, 5'd1, 7'b1110011}, 32'hcafe_f00d,
                1'b1, 32'h0000_0002, 32'h0000_0088);      // csrrw dropped
    run_csr(3'b010, ADRS[1], 5'd0, 5'd1, '0);

    test_name = "random";  // includes non-csr funct3 and rare traps
    for (int k = 0; k < 200; k++) begin
      r = $random(seed);
      drive_cycle(1'b1, {ADRS[r[2:0]], r[7:3], r[10:8], r[15:11], 7'b1110011},
                  $random(seed), r[20:16] == 5'd0, $random(seed), $random(seed));
    end
    report_verdict();
  end

endmodule

//--- tests/csr_unit_checker.sv
////////////////////////////////////////
// port-level assertions, bound into
// every csr_unit instance
////////////////////////////////////////

`timescale 1ns/1ns

module csr_unit_checker (
  input logic                 clk,
  input logic                 rst,
  input logic                 inst_vld_i,
  input logic [31:0]          inst_i,
  input logic                 trap_i,
  input csr_reg_pkg::csr_wb_t wb_o
);

  int unsigned fail_cnt = 0;  // failed assertions so far
  logic        csr_op;        // strobe with a Zicsr funct3

  assign csr_op = inst_vld_i && inst_i[6:0] == 7'b1110011 && inst_i[13:12] != 2'b00;

  // result exactly one cycle after an op that no trap cancels
  a_vld_follows: assert property (@(posedge clk) disable iff (rst)
    wb_o.vld == $past(csr_op && !trap_i))
    else begin
      $error("wb_o.vld does not follow the instruction strobe");
      fail_cnt++;
    end

  a_ill_zero: assert property (@(posedge clk) disable iff (rst)
    wb_o.ill |-> wb_o.rdt == '0)
    else begin
      $error("illegal result carries nonzero data");
      fail_cnt++;
    end

  a_idle_after_rst: assert property (@(posedge clk) rst |=> !wb_o.vld && !wb_o.ill)
    else begin
      $error("result valid or illegal right after reset");
      fail_cnt++;
    end

  a_trap_drop: assert property (@(posedge clk) disable iff (rst) trap_i |=> !wb_o.vld)
    else begin
      $error("trap cycle produced a result");
      fail_cnt++;
    end

endmodule

bind csr_unit csr_unit_checker u_checker (
  .clk        (clk),
  .rst        (rst),
  .inst_vld_i (inst_vld_i),
  .inst_i     (inst_i),
  .trap_i     (trap_i),
  .wb_o       (wb_o)
);

//--- rtl/csr_unit.sv
////////////////////////////////////////
// M-mode Zicsr unit top
// decode -> execute -> result
////////////////////////////////////////

`timescale 1ns/1ns

module csr_unit #(
  parameter int unsigned     XLEN    = 32,
  parameter logic [XLEN-1:0] MTVEC   = XLEN'(32'h0000_0100),
  parameter logic [XLEN-1:0] HART_ID = '0
)(
  input  logic                 clk,
  input  logic                 rst,
  // instruction strobe
  input  logic                 inst_vld_i,
  input  logic [31:0]          inst_i,
  input  logic [XLEN-1:0]      rs1_i,
  // trap request
  input  logic                 trap_i,
  input  logic [XLEN-1:0]      cause_i,
  input  logic [XLEN-1:0]      epc_i,
  // results
  output csr_reg_pkg::csr_wb_t wb_o,
  output logic [XLEN-1:0]      tvec_o,
  output logic [XLEN-1:0]      epc_o
);

  csr_isa_pkg::ctl_csr_t ctl;  // decoded control
  logic [XLEN-1:0]       rdt;  // old csr value
  logic                  ill;

  csr_decode u_decode (
    .inst_vld_i (inst_vld_i),
    .inst_i     (inst_i),
    .ctl_o      (ctl)
  );

  csr_file #(
    .XLEN    (XLEN),
    .MTVEC   (MTVEC),
    .HART_ID (HART_ID)
  ) u_file (
    .clk     (clk),
    .rst     (rst),
    .ctl_i   (ctl),
    .rs1_i   (rs1_i),
    .trap_i  (trap_i),
    .cause_i (cause_i),
    .epc_i   (epc_i),
    .rdt_o   (rdt),
    .ill_o   (ill),
    .tvec_o  (tvec_o),
    .epc_o   (epc_o)
  );

  // vld and rd bypass execute straight into the result stage
  csr_result #(
    .XLEN (XLEN)
  ) u_result (
    .clk    (clk),
    .rst    (rst),
    .vld_i  (ctl.vld),
    .rd_i   (ctl.rd),
    .rdt_i  (rdt),
    .ill_i  (ill),
    .trap_i (trap_i),
    .wb_o   (wb_o)
  );

endmodule

//--- rtl/csr_result.sv
////////////////////////////////////////
// result register, one cycle of latency
// no back-pressure on wb_o
////////////////////////////////////////

`timescale 1ns/1ns

module csr_result #(
  parameter int unsigned XLEN = 32
)(
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 vld_i,   // decoded csr op
  input  logic [4:0]           rd_i,
  input  logic [XLEN-1:0]      rdt_i,   // old value from execute
  input  logic                 ill_i,
  input  logic                 trap_i,  // cancels this cycle's op
  output csr_reg_pkg::csr_wb_t wb_o
);

  localparam int unsigned WBW = csr_reg_pkg::WB_XLEN;

  logic            vld_q;
  logic            ill_q;
  logic [4:0]      rd_q;
  logic [XLEN-1:0] rdt_q;

  // control, pulses for one cycle
  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      vld_q <= 1'b0;
      ill_q <= 1'b0;
    end else begin
      vld_q <= vld_i & ~trap_i;
      ill_q <= vld_i & ~trap_i & ill_i;
    end
  end

  // payload, loaded with a live op only
  always_ff @(posedge clk) begin
    if (vld_i) begin
      rd_q  <= rd_i;
      rdt_q <= ill_i ? '0 : rdt_i;  // no data leaks on illegal
    end
  end

  always_comb begin
    wb_o.vld = vld_q;
    wb_o.ill = ill_q;
    wb_o.rd  = rd_q;
    wb_o.rdt = WBW'(rdt_q);  // low word at XLEN 64
  end

endmodule

//--- rtl/csr_file.sv
////////////////////////////////////////
// execute stage, M-mode registers only
// misa is fixed, writes to it are ignored
////////////////////////////////////////

`timescale 1ns/1ns

module csr_file #(
  parameter int unsigned     XLEN    = 32,
  parameter logic [XLEN-1:0] MTVEC   = '0,  // trap vector after reset
  parameter logic [XLEN-1:0] HART_ID = '0   // mhartid value
)(
  input  logic                  clk,
  input  logic                  rst,
  input  csr_isa_pkg::ctl_csr_t ctl_i,    // decoded control
  input  logic [XLEN-1:0]       rs1_i,    // GPR source data
  input  logic                  trap_i,   // one-cycle trap request
  input  logic [XLEN-1:0]       cause_i,
  input  logic [XLEN-1:0]       epc_i,
  output logic [XLEN-1:0]       rdt_o,    // old value, comb
  output logic                  ill_o,    // illegal access
  output logic [XLEN-1:0]       tvec_o,
  output logic [XLEN-1:0]       epc_o
);

  // MXL field, 1 for RV32, 2 for RV64
  localparam logic [1:0]      MXL  = (XLEN == 64) ? 2'd2 : 2'd1;
  // base integer ISA, extension bit I only
  localparam logic [XLEN-1:0] MISA = {MXL, {(XLEN-28){1'b0}}, 26'h000_0100};

  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  logic            hit;     // address implemented
  logic [XLEN-1:0] old;     // current value at adr
  logic            ro;      // perm says read-only
  logic            lvl_ok;  // level field is M
  logic [XLEN-1:0] msk;     // operand, rs1 or uimm
  logic [XLEN-1:0] wdt;     // new value
  logic            we;      // commit the write

  ////////////////////////////////////////
  // address decode and read
  ////////////////////////////////////////

  always_comb begin
    hit = 1'b1;
    case (ctl_i.adr.idx)
      csr_reg_pkg::ADR_MISA:     old = MISA;
      csr_reg_pkg::ADR_MSCRATCH: old = mscratch_q;
      csr_reg_pkg::ADR_MTVEC:    old = mtvec_q;
      csr_reg_pkg::ADR_MEPC:     old = mepc_q;
      csr_reg_pkg::ADR_MCAUSE:   old = mcause_q;
      csr_reg_pkg::ADR_MHARTID:  old = HART_ID;
      default: begin
        hit = 1'b0;  // unimplemented
        old = '0;
      end
    endcase
  end

  // descriptor view of the same address word
  assign ro     = (ctl_i.adr.fld.perm == csr_reg_pkg::ACCESS_RO3);
  assign lvl_ok = (ctl_i.adr.fld.level == csr_reg_pkg::LVL_M);

  assign ill_o = ctl_i.vld & (~hit | ~lvl_ok | (ctl_i.wen & ro));

  assign rdt_o = ctl_i.ren ? old : '0;  // nothing to report on csrrw x0

  ////////////////////////////////////////
  // operation
  ////////////////////////////////////////

  always_comb begin
    case (ctl_i.src)
      csr_isa_pkg::CSR_IMM: msk = XLEN'(ctl_i.imm);  // zero extended
      default:              msk = rs1_i;
    endcase
  end

  always_comb begin
    case (ctl_i.op)
      csr_isa_pkg::CSR_RW:  wdt = msk;
      csr_isa_pkg::CSR_SET: wdt = old | msk;
      csr_isa_pkg::CSR_CLR: wdt = old & ~msk;
      default:              wdt = old;  // unused encoding
    endcase
  end

  // a trap in the same cycle drops the instruction
  assign we = ctl_i.vld & ctl_i.wen & ~ill_o & ~trap_i;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      mscratch_q <= '0;
      mtvec_q    <= MTVEC;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else if (trap_i) begin
      mepc_q   <= epc_i;    // trap wins
      mcause_q <= cause_i;
    end else if (we) begin
      case (ctl_i.adr.idx)
        csr_reg_pkg::ADR_MSCRATCH: mscratch_q <= wdt;
        csr_reg_pkg::ADR_MTVEC:    mtvec_q    <= wdt;
        csr_reg_pkg::ADR_MEPC:     mepc_q     <= wdt;
        csr_reg_pkg::ADR_MCAUSE:   mcause_q   <= wdt;
        default: begin
          // misa fixed, mhartid never gets here
        end
      endcase
    end
  end

  assign tvec_o = mtvec_q;
  assign epc_o  = mepc_q;

endmodule

//--- rtl/csr_decode.sv
////////////////////////////////////////
// SYSTEM decode, purely combinational
// non-CSR SYSTEM ops give vld low
////////////////////////////////////////

`timescale 1ns/1ns

module csr_decode (
  input  logic                  inst_vld_i,  // single-cycle strobe
  input  logic [31:0]           inst_i,
  output csr_isa_pkg::ctl_csr_t ctl_o
);

  csr_isa_pkg::inst_sys_t inst;   // field view of inst_i
  logic                   sys;    // SYSTEM major opcode
  logic                   zicsr;  // funct3 names a CSR op

  assign inst = inst_i;
  assign sys  = (inst.opcode == csr_isa_pkg::OPC_SYSTEM);

  always_comb begin
    ctl_o = '0;
    zicsr = 1'b1;

    // operation and source from funct3
    case (inst.funct3)
      3'b001: begin
        ctl_o.op  = csr_isa_pkg::CSR_RW;   // csrrw
        ctl_o.src = csr_isa_pkg::CSR_REG;
      end
      3'b010: begin
        ctl_o.op  = csr_isa_pkg::CSR_SET;  // csrrs
        ctl_o.src = csr_isa_pkg::CSR_REG;
      end
      3'b011: begin
        ctl_o.op  = csr_isa_pkg::CSR_CLR;  // csrrc
        ctl_o.src = csr_isa_pkg::CSR_REG;
      end
      3'b101: begin
        ctl_o.op  = csr_isa_pkg::CSR_RW;   // csrrwi
        ctl_o.src = csr_isa_pkg::CSR_IMM;
      end
      3'b110: begin
        ctl_o.op  = csr_isa_pkg::CSR_SET;  // csrrsi
        ctl_o.src = csr_isa_pkg::CSR_IMM;
      end
      3'b111: begin
        ctl_o.op  = csr_isa_pkg::CSR_CLR;  // csrrci
        ctl_o.src = csr_isa_pkg::CSR_IMM;
      end
      default: begin
        zicsr = 1'b0;  // ecall/ebreak/xret/wfi, reserved
      end
    endcase

    ctl_o.vld     = inst_vld_i & sys & zicsr;
    ctl_o.imm     = inst.rs1;  // uimm shares the rs1 slot
    ctl_o.rd      = inst.rd;
    ctl_o.adr.idx = inst.csr;

    // csrrw to x0 reads nothing visible
    ctl_o.ren = ctl_o.vld &
                ~((ctl_o.op == csr_isa_pkg::CSR_RW) && (inst.rd == 5'd0));

    // set/clear with x0 or zero uimm must not write,
    // keeps reads of read-only registers legal
    ctl_o.wen = ctl_o.vld &
                ~((ctl_o.op != csr_isa_pkg::CSR_RW) && (inst.rs1 == 5'd0));
  end

endmodule

//--- rtl/csr_isa_pkg.sv
////////////////////////////////////////
// Zicsr instruction encoding and the
// decoded control word
////////////////////////////////////////

package csr_isa_pkg;

  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;  // major opcode

  // I-type field layout of a SYSTEM instruction
  typedef struct packed {
    logic [11:0] csr;     // CSR address
    logic [4:0]  rs1;     // source GPR or uimm
    logic [2:0]  funct3;  // operation and source
    logic [4:0]  rd;      // destination GPR
    logic [6:0]  opcode;
  } inst_sys_t;

  // encoding matches funct3[1:0]
  typedef enum logic [1:0] {
    CSR_RW  = 2'b01,  // read/write
    CSR_SET = 2'b10,  // read and set bits
    CSR_CLR = 2'b11   // read and clear bits
  } csr_op_t;

  // encoding matches funct3[2]
  typedef enum logic {
    CSR_REG = 1'b0,  // rs1 data
    CSR_IMM = 1'b1   // zero-extended uimm
  } csr_src_t;

  ////////////////////////////////////////
  // decoded control, 28 bits
  ////////////////////////////////////////
  typedef struct packed {
    logic                   vld;  // csr operation present
    csr_op_t                op;
    csr_src_t               src;
    logic [4:0]             imm;  // uimm, also the rs1 index
    logic [4:0]             rd;
    csr_reg_pkg::csr_adr_ut adr;
    logic                   ren;  // read has a side to report
    logic                   wen;  // write requested
  } ctl_csr_t;

endpackage

//--- rtl/csr_reg_pkg.sv
////////////////////////////////////////
// machine-level CSR map, M mode only
// wb_o.rdt is fixed at WB_XLEN bits
////////////////////////////////////////

package csr_reg_pkg;

  ////////////////////////////////////////
  // address descriptor fields
  ////////////////////////////////////////

  // csr[11:10], access class
  typedef enum logic [1:0] {
    ACCESS_RW0 = 2'b00,  // read/write
    ACCESS_RW1 = 2'b01,  // read/write
    ACCESS_RW2 = 2'b10,  // read/write
    ACCESS_RO3 = 2'b11   // read-only
  } csr_perm_t;

  // csr[9:8], lowest level allowed to access
  typedef enum logic [1:0] {
    LVL_U = 2'b00,  // user
    LVL_S = 2'b01,  // supervisor
    LVL_R = 2'b10,  // reserved (hypervisor)
    LVL_M = 2'b11   // machine
  } isa_level_t;

  // one 12-bit CSR address, seen as a number or as a descriptor
  typedef union packed {
    logic [11:0] idx;        // raw index for address compare
    struct packed {
      csr_perm_t  perm;
      isa_level_t level;
      logic [7:0] num;
    } fld;                   // access descriptor view
  } csr_adr_ut;

  // implemented machine registers
  localparam logic [11:0] ADR_MISA     = 12'h301;
  localparam logic [11:0] ADR_MTVEC    = 12'h305;
  localparam logic [11:0] ADR_MSCRATCH = 12'h340;
  localparam logic [11:0] ADR_MEPC     = 12'h341;
  localparam logic [11:0] ADR_MCAUSE   = 12'h342;
  localparam logic [11:0] ADR_MHARTID  = 12'hF14;  // read-only by perm

  localparam int unsigned WB_XLEN = 32;  // writeback data width

  // writeback to the core
  typedef struct packed {
    logic               vld;  // result valid, one cycle
    logic               ill;  // illegal access
    logic [4:0]         rd;   // destination GPR
    logic [WB_XLEN-1:0] rdt;  // old CSR value
  } csr_wb_t;

endpackage
